/* Makefile */
# Verilator build and run of the router testbench
VERILATOR ?= verilator
TOP       ?= router_host_tb
FILELIST  ?= router_host.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

SRCS := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass only if the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/data_whitener.sv */
// Data whitening with a 64-bit Fibonacci LFSR, taps 63, 31 and 15
// LFSR steps once per start, whether or not the packet is later dropped
`include "router_defs.svh"

module data_whitener (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [`ROUTER_DATA_WIDTH-1:0] packet_data,
    input  logic                          seq_in,
    route_if.src                          res
);

    logic [63:0] lfsr;
    logic [63:0] lfsr_next;

    assign lfsr_next = {lfsr[62:0], lfsr[63] ^ lfsr[31] ^ lfsr[15]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `ROUTER_LFSR_SEED;
        end else if (start) begin
            lfsr <= lfsr_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res.valid <= 1'b0;
            res.seq   <= 1'b0;
        end else if (start) begin
            res.valid <= 1'b1;
            res.seq   <= seq_in;
        end else if (res.ready) begin
            res.valid <= 1'b0;
        end
    end

    // Whitened with the state from before this packet's step
    always_ff @(posedge clk) begin
        if (start) begin
            res.payload <= packet_data ^ lfsr[`ROUTER_DATA_WIDTH-1:0];
        end
    end

    // Word must not move while the merge stage stalls it
    a_payload_stable: assert property (
        @(posedge clk) disable iff (rst)
        (res.valid && !res.ready) |=> (res.valid && $stable(res.payload))
    ) else $error("data_whitener: payload changed while stalled");

endmodule

/* hdl/port_lookup.sv */
// Port selection from a fixed table indexed by the top address bits
// Table contents are set at reset and cannot be rewritten
`include "router_defs.svh"

module port_lookup (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [`ROUTER_ADDR_WIDTH-1:0] dest_addr,
    input  logic                          seq_in,
    route_if.src                          res
);

    router_pkg::port_t   route_table [`ROUTER_PORT_COUNT];
    router_pkg::lookup_t next_res;

    // Entry i maps to the mirrored port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ROUTER_PORT_COUNT; i++) begin
                route_table[i] <= router_pkg::port_t'(`ROUTER_PORT_COUNT - 1 - i);
            end
        end
    end

    always_comb begin
        next_res.port = route_table[dest_addr[`ROUTER_ADDR_WIDTH-1 -: `ROUTER_PORT_BITS]];
        next_res.drop = (dest_addr == `ROUTER_ADDR_WIDTH'(`ROUTER_NULL_ADDR));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res.valid <= 1'b0;
            res.seq   <= 1'b0;
        end else if (start) begin
            res.valid <= 1'b1;
            res.seq   <= seq_in;
        end else if (res.ready) begin
            res.valid <= 1'b0;  // Taken by the merge stage
        end
    end

    // Result held until the transfer
    always_ff @(posedge clk) begin
        if (start) begin
            res.payload <= next_res;
        end
    end

    // Input side must not restart while a result is still pending
    a_no_start_while_valid: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !res.valid
    ) else $error("port_lookup: start while result pending");

endmodule

/* hdl/route_if.sv */
// Valid/ready link between router blocks; one transfer per valid&ready edge
// Producer holds valid, payload and seq stable until the transfer
interface route_if #(
    parameter type payload_t = logic [31:0]
);

    logic     valid;
    logic     ready;
    payload_t payload;
    logic     seq;     // Sequence parity of the packet being carried

    // Producer side
    modport src (
        output valid,
        output payload,
        output seq,
        input  ready
    );

    // Consumer side
    modport dst (
        input  valid,
        input  payload,
        input  seq,
        output ready
    );

endinterface

/* hdl/route_merge.sv */
// Joins lookup and whitened word, then drives the output req/ack handshake
// Dropped packets skip the handshake and bump a wrapping counter
`include "router_defs.svh"

module route_merge (
    input  logic                          clk,
    input  logic                          rst,
    route_if.dst                          lk,
    route_if.dst                          wd,
    input  logic                          out_ack,
    output logic                          out_req,
    output logic [`ROUTER_DATA_WIDTH-1:0] routed_data,
    output router_pkg::port_t             output_port,
    output logic [`ROUTER_DROP_BITS-1:0]  drop_count,
    output logic                          busy
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_DECIDE,    // Results captured, send or drop next
        M_REQ,       // out_req high, waiting for ack
        M_WAIT_LOW   // Waiting for ack to return to zero
    } merge_state_t;

    merge_state_t        state;
    router_pkg::lookup_t lk_res;
    logic                take;
    logic                drop_q;

    assign lk_res = lk.payload;

    // Both results taken on the same edge
    assign take     = (state == M_IDLE) && lk.valid && wd.valid;
    assign lk.ready = take;
    assign wd.ready = take;

    assign busy = (state != M_IDLE) || lk.valid || wd.valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= M_IDLE;
            out_req    <= 1'b0;
            drop_count <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (take) state <= M_DECIDE;
                end
                M_DECIDE: begin
                    if (drop_q) begin
                        drop_count <= drop_count + 1'b1;
                        state      <= M_IDLE;
                    end else begin
                        out_req <= 1'b1;
                        state   <= M_REQ;
                    end
                end
                M_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= M_WAIT_LOW;
                    end
                end
                M_WAIT_LOW: begin
                    if (!out_ack) state <= M_IDLE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // Output values stay put until the next packet is taken
    always_ff @(posedge clk) begin
        if (take) begin
            routed_data <= wd.payload;
            output_port <= lk_res.port;
            drop_q      <= lk_res.drop;
        end
    end

    // Both producers must be working on the same packet
    a_seq_match: assert property (
        @(posedge clk) disable iff (rst)
        take |-> (lk.seq == wd.seq)
    ) else $error("route_merge: lookup and whitener out of step");

endmodule

/* hdl/router_defs.svh */
// Widths and constants shared by the router RTL and testbench
// ROUTER_PORT_BITS must equal log2 of ROUTER_PORT_COUNT
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Packet fields
`define ROUTER_ADDR_WIDTH 8
`define ROUTER_DATA_WIDTH 32

// Output ports, selected by the top address bits
`define ROUTER_PORT_COUNT 4
`define ROUTER_PORT_BITS  2

// Whitening LFSR reset value
`define ROUTER_LFSR_SEED 64'h1234567890ABCDEF

`define ROUTER_NULL_ADDR 0  // Reserved destination, always dropped
`define ROUTER_DROP_BITS 8  // Drop counter wraps at this width

`endif

/* hdl/router_host.sv */
// Router top; four-phase req/ack on both sides, one packet in flight
// Source must hold dest_addr and packet_data until in_ack rises
`include "router_defs.svh"

module router_host (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_req,
    output logic                          in_ack,
    input  logic [`ROUTER_ADDR_WIDTH-1:0] dest_addr,
    input  logic [`ROUTER_DATA_WIDTH-1:0] packet_data,
    output logic                          out_req,
    input  logic                          out_ack,
    output logic [`ROUTER_DATA_WIDTH-1:0] routed_data,
    output router_pkg::port_t             output_port,
    output logic [`ROUTER_DROP_BITS-1:0]  drop_count
);

    typedef enum logic [1:0] {
        IN_IDLE,
        IN_ACK,      // First ack cycle, start strobe high
        IN_WAIT_LOW  // Ack held until the source drops req
    } in_state_t;

    in_state_t state;
    logic      start;
    logic      seq_q;
    logic      merge_busy;

    route_if #(.payload_t(router_pkg::lookup_t))           lk_if ();
    route_if #(.payload_t(logic [`ROUTER_DATA_WIDTH-1:0])) wd_if ();

    assign start  = (state == IN_ACK);
    assign in_ack = (state != IN_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IN_IDLE;
            seq_q <= 1'b0;
        end else begin
            case (state)
                IN_IDLE: begin
                    if (in_req && !merge_busy) begin  // Stall while a packet is in flight
                        state <= IN_ACK;
                        seq_q <= ~seq_q;
                    end
                end
                IN_ACK: begin
                    state <= in_req ? IN_WAIT_LOW : IN_IDLE;
                end
                IN_WAIT_LOW: begin
                    if (!in_req) state <= IN_IDLE;
                end
                default: state <= IN_IDLE;
            endcase
        end
    end

    port_lookup lookup_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .dest_addr (dest_addr),
        .seq_in    (seq_q),
        .res       (lk_if)
    );

    data_whitener whitener_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .packet_data (packet_data),
        .seq_in      (seq_q),
        .res         (wd_if)
    );

    route_merge merge_i (
        .clk         (clk),
        .rst         (rst),
        .lk          (lk_if),
        .wd          (wd_if),
        .out_ack     (out_ack),
        .out_req     (out_req),
        .routed_data (routed_data),
        .output_port (output_port),
        .drop_count  (drop_count),
        .busy        (merge_busy)
    );

endmodule

/* hdl/router_pkg.sv */
// Types passed between the router blocks
// Widths come from router_defs.svh
`include "router_defs.svh"

package router_pkg;

    // Output port index
    typedef logic [`ROUTER_PORT_BITS-1:0] port_t;

    // Result of the routing table lookup
    typedef struct packed {
        port_t port;  // Selected output port
        logic  drop;  // Packet addressed to the null destination
    } lookup_t;

endpackage

/* router_host.f */
+incdir+hdl
hdl/router_pkg.sv
hdl/route_if.sv
hdl/port_lookup.sv
hdl/data_whitener.sv
hdl/route_merge.sv
hdl/router_host.sv
tb/router_host_tb.sv

/* tb/router_host_tb.sv */
// Directed tests for router_host; the reference model follows the LFSR and table rules
// Outputs are sampled and inputs driven on the falling clock edge
`include "router_defs.svh"

module router_host_tb;

    localparam int NUM_PACKETS = 29;                  // 1 + 20 + 2 + 2 + 4
    localparam int CYCLE_LIMIT = 16 + 200 * NUM_PACKETS;
    localparam int WAIT_LIMIT  = 100;                 // Bound on any single handshake wait

    logic                          clk;
    logic                          rst;
    logic                          in_req;
    logic                          in_ack;
    logic [`ROUTER_ADDR_WIDTH-1:0] dest_addr;
    logic [`ROUTER_DATA_WIDTH-1:0] packet_data;
    logic                          out_req;
    logic                          out_ack;
    logic [`ROUTER_DATA_WIDTH-1:0] routed_data;
    router_pkg::port_t             output_port;
    logic [`ROUTER_DROP_BITS-1:0]  drop_count;

    // Reference model state
    logic [63:0]                   model_lfsr;
    logic [`ROUTER_DROP_BITS-1:0]  exp_drops;
    logic [`ROUTER_DATA_WIDTH-1:0] exp_data_q[$];
    router_pkg::port_t             exp_port_q[$];

    int     mismatches;
    int     failures;
    integer seed = 32'ha48df318;

    router_host dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_req      (in_req),
        .in_ack      (in_ack),
        .dest_addr   (dest_addr),
        .packet_data (packet_data),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .routed_data (routed_data),
        .output_port (output_port),
        .drop_count  (drop_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH time %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("ERROR time %0t: %s", $time, what);
    endtask

    // Model one accepted packet, then step the LFSR
    task automatic model_accept(input logic [`ROUTER_ADDR_WIDTH-1:0] addr,
                                input logic [`ROUTER_DATA_WIDTH-1:0] data);
        if (addr == `ROUTER_ADDR_WIDTH'(`ROUTER_NULL_ADDR)) begin
            exp_drops++;
        end else begin
            exp_data_q.push_back(data ^ model_lfsr[31:0]);
            exp_port_q.push_back(~addr[`ROUTER_ADDR_WIDTH-1 -: `ROUTER_PORT_BITS]);
        end
        model_lfsr = {model_lfsr[62:0], model_lfsr[63] ^ model_lfsr[31] ^ model_lfsr[15]};
    endtask

    task automatic raise_request(input logic [`ROUTER_ADDR_WIDTH-1:0] addr,
                                 input logic [`ROUTER_DATA_WIDTH-1:0] data);
        @(negedge clk);
        dest_addr   = addr;
        packet_data = data;
        in_req      = 1'b1;
    endtask

    // Wait for ack, then return to zero
    task automatic complete_request();
        int n;
        n = 0;
        while (!in_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (in_ack) else report_failure("in_ack did not rise for a pending request");
        model_accept(dest_addr, packet_data);
        in_req = 1'b0;
        n = 0;
        while (in_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (!in_ack) else report_failure("in_ack stayed high after in_req fell");
    endtask

    task automatic send_packet(input logic [`ROUTER_ADDR_WIDTH-1:0] addr,
                               input logic [`ROUTER_DATA_WIDTH-1:0] data);
        raise_request(addr, data);
        complete_request();
    endtask

    task automatic expect_output();
        int n;
        n = 0;
        while (!out_req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (out_req) else report_failure("out_req did not rise for an expected packet");
        assert (exp_data_q.size() > 0) else report_failure("output seen with no packet modelled");
        if (exp_data_q.size() > 0) begin
            check_value("routed_data", 64'(routed_data), 64'(exp_data_q.pop_front()));
            check_value("output_port", 64'(output_port), 64'(exp_port_q.pop_front()));
        end
        out_ack = 1'b1;
        n = 0;
        while (out_req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (!out_req) else report_failure("out_req stayed high after out_ack");
        out_ack = 1'b0;
    endtask

    task automatic test_reset_state();
        check_value("in_ack", 64'(in_ack), 64'd0);
        check_value("out_req", 64'(out_req), 64'd0);
        check_value("drop_count", 64'(drop_count), 64'd0);
    endtask

    task automatic test_single_packet();
        send_packet(8'h5A, 32'hCAFEF00D);
        expect_output();
    endtask

    task automatic test_random_stream();
        logic [`ROUTER_ADDR_WIDTH-1:0] addr;
        for (int i = 0; i < 20; i++) begin
            addr = `ROUTER_ADDR_WIDTH'($random(seed));
            if (addr == `ROUTER_ADDR_WIDTH'(`ROUTER_NULL_ADDR)) addr = 8'h01;  // Keep it routable
            send_packet(addr, $random(seed));
            expect_output();
        end
    endtask

    task automatic test_null_drop();
        send_packet(`ROUTER_ADDR_WIDTH'(`ROUTER_NULL_ADDR), $random(seed));
        repeat (6) begin
            @(negedge clk);
            assert (!out_req) else report_failure("out_req raised for a dropped packet");
        end
        check_value("drop_count", 64'(drop_count), 64'(exp_drops));
        // Whitening must reflect the step taken by the dropped packet
        send_packet(8'h80, $random(seed));
        expect_output();
    endtask

    task automatic test_back_pressure();
        logic [`ROUTER_DATA_WIDTH-1:0] held_data;
        router_pkg::port_t             held_port;
        int                            n;
        send_packet(8'h3C, $random(seed));
        n = 0;
        while (!out_req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        held_data = routed_data;
        held_port = output_port;
        raise_request(8'hC3, $random(seed));
        repeat (30) begin
            @(negedge clk);
            assert (out_req) else report_failure("out_req dropped while out_ack held low");
            assert (!in_ack) else report_failure("second packet acknowledged during stall");
            check_value("routed_data", 64'(routed_data), 64'(held_data));
            check_value("output_port", 64'(output_port), 64'(held_port));
        end
        expect_output();
        complete_request();
        expect_output();
    endtask

    task automatic test_all_ports();
        logic [3:0] seen;
        seen = '0;
        foreach (seen[i]) begin
            send_packet(8'(i * 64 + 21), $random(seed));  // One address per top-bit range
            expect_output();
            seen[output_port] = 1'b1;
        end
        assert (seen == 4'hF) else report_failure("not every output port was reached");
    endtask

    initial begin
        rst         = 1'b1;
        in_req      = 1'b0;
        out_ack     = 1'b0;
        dest_addr   = '0;
        packet_data = '0;
        mismatches  = 0;
        failures    = 0;
        model_lfsr  = `ROUTER_LFSR_SEED;
        exp_drops   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_single_packet();
        test_random_stream();
        test_null_drop();
        test_back_pressure();
        test_all_ports();

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, scaled by packet count
    initial begin
        #(CYCLE_LIMIT * 4);
        $display("ERROR time %0t: watchdog expired before the tests finished", $time);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule
